/* hdl/replay_pkg.sv */
// Widths, register map and types shared by the packet replay engine
// The memory holds 256 words, and each stored word carries the packet-last flag on top
package replay_pkg;

  localparam int NUM_QUEUES = 4;
  localparam int NUM_REQ    = NUM_QUEUES + 1;
  // Capture takes the requester slot above the queues
  localparam int CAP_IDX    = NUM_QUEUES;
  localparam int REQ_IDX_W  = $clog2(NUM_REQ);

  localparam int WORD_W     = 32;
  localparam int ADDR_W     = 8;
  localparam int MEM_DEPTH  = 1 << ADDR_W;
  localparam int CNT_W      = 16;
  localparam int REG_ADDR_W = 5;
  localparam int REG_W      = 32;

  // Register indices
  localparam int REG_SW_RST      = 0;
  localparam int REG_START_BASE  = 1;
  localparam int REG_COUNT_BASE  = 5;
  localparam int REG_ADDR_BASE   = 9;   // low/high pairs, one pair per queue
  localparam int REG_ENABLE_BASE = 17;
  localparam int NUM_REGS        = 21;

  typedef logic [WORD_W-1:0]     pkt_data_t;
  typedef logic [WORD_W:0]       mem_word_t;
  typedef logic [ADDR_W-1:0]     mem_addr_t;
  typedef logic [CNT_W-1:0]      replay_cnt_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_W-1:0]      reg_data_t;
  typedef logic [NUM_REQ-1:0]    req_vec_t;
  typedef logic [REQ_IDX_W-1:0]  req_idx_t;

  typedef enum logic [1:0] {Q_IDLE, Q_RUN, Q_DRAIN} queue_state_t;

endpackage

/* hdl/replay_regs.sv */
// Register file on plain strobes, read data valid one cycle after reg_rd
// Indices at or above NUM_REGS read as zero and ignore writes
// sw_rst is only a field here, it does not clear this block
`timescale 1ns/1ps

module replay_regs import replay_pkg::*; (
  input  logic        axi_aclk,
  input  logic        rst,
  input  logic        reg_wr,
  input  logic        reg_rd,
  input  reg_addr_t   reg_addr,
  input  reg_data_t   reg_wdata,
  output reg_data_t   reg_rdata,
  output logic        reg_rvalid,
  output logic        sw_rst,
  output logic [NUM_QUEUES-1:0] start,
  output logic [NUM_QUEUES-1:0] enable,
  output replay_cnt_t replay_count [NUM_QUEUES],
  output mem_addr_t   addr_low [NUM_QUEUES],
  output mem_addr_t   addr_high [NUM_QUEUES]
);

  reg_data_t regs [NUM_REGS];
  logic      addr_ok;

  assign addr_ok = (int'(reg_addr) < NUM_REGS);

  // Write port
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr && addr_ok) begin
      regs[reg_addr] <= reg_wdata;
    end
  end

  // Registered read
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      reg_rvalid <= 1'b0;
      reg_rdata  <= '0;
    end else begin
      reg_rvalid <= reg_rd;
      if (reg_rd) begin
        reg_rdata <= addr_ok ? regs[reg_addr] : '0;
      end
    end
  end

  // Slice registers into per-queue fields
  always_comb begin
    sw_rst = regs[REG_SW_RST][0];
    for (int q = 0; q < NUM_QUEUES; q++) begin
      start[q]        = regs[REG_START_BASE + q][0];
      replay_count[q] = regs[REG_COUNT_BASE + q][CNT_W-1:0];
      addr_low[q]     = regs[REG_ADDR_BASE + 2*q][ADDR_W-1:0];
      addr_high[q]    = regs[REG_ADDR_BASE + 2*q + 1][ADDR_W-1:0];
      enable[q]       = regs[REG_ENABLE_BASE + q][0];
    end
  end

endmodule

/* hdl/pkt_capture.sv */
// Writes input stream words into packet memory in arrival order
// s_ready is the arbiter grant, the write pointer wraps at the memory size
`timescale 1ns/1ps

module pkt_capture import replay_pkg::*; (
  input  logic      axi_aclk,
  input  logic      rst,
  input  logic      sw_rst,
  input  logic      s_valid,
  input  logic      s_last,
  input  pkt_data_t s_data,
  input  logic      gnt,
  output logic      s_ready,
  output logic      req,
  output logic      wr_en,
  output mem_addr_t wr_addr,
  output mem_word_t wr_data
);

  mem_addr_t wr_ptr;

  // Ask for the memory whenever a word is waiting
  assign req     = s_valid;
  assign s_ready = gnt;
  assign wr_en   = s_valid & gnt;
  assign wr_addr = wr_ptr;
  // Last flag rides above the data
  assign wr_data = {s_last, s_data};

  always_ff @(posedge axi_aclk) begin
    if (rst || sw_rst) begin
      wr_ptr <= '0;
    end else if (s_valid && gnt) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

endmodule

/* hdl/mem_arbiter.sv */
// Round-robin arbiter for the single memory port, one grant per cycle
// Search starts after the last requester granted, grant is same-cycle
// rd_ret marks the queue whose read data shows up this cycle
`timescale 1ns/1ps

module mem_arbiter import replay_pkg::*; (
  input  logic      axi_aclk,
  input  logic      rst,
  input  req_vec_t  req,
  input  mem_addr_t req_addr [NUM_REQ],
  input  logic      cap_wr_en,
  input  mem_word_t cap_wr_data,
  output req_vec_t  gnt,
  output logic      mem_en,
  output logic      mem_we,
  output mem_addr_t mem_addr,
  output mem_word_t mem_wdata,
  output logic [NUM_QUEUES-1:0] rd_ret
);

  req_idx_t last_q;
  req_idx_t sel;
  logic     found;

  always_comb begin
    int idx;
    found = 1'b0;
    sel   = last_q;
    for (int i = 1; i <= NUM_REQ; i++) begin
      idx = (int'(last_q) + i) % NUM_REQ;
      if (!found && req[idx]) begin
        found = 1'b1;
        sel   = req_idx_t'(idx);
      end
    end
  end

  always_comb begin
    gnt      = '0;
    gnt[sel] = found;
  end

  // Memory port mux
  assign mem_en    = found;
  assign mem_we    = gnt[CAP_IDX] & cap_wr_en;
  assign mem_addr  = req_addr[sel];
  assign mem_wdata = cap_wr_data;

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      last_q <= req_idx_t'(NUM_REQ - 1);
      rd_ret <= '0;
    end else begin
      if (found) begin
        last_q <= sel;
      end
      // Read data lands one cycle after the grant
      rd_ret <= gnt[NUM_QUEUES-1:0];
    end
  end

endmodule

/* hdl/pkt_mem.sv */
// Single-port packet memory, read data registered one cycle after mem_en
// No read-during-write path, the arbiter grants one access per cycle
`timescale 1ns/1ps

module pkt_mem import replay_pkg::*; (
  input  logic      axi_aclk,
  input  logic      mem_en,
  input  logic      mem_we,
  input  mem_addr_t mem_addr,
  input  mem_word_t mem_wdata,
  output mem_word_t rd_data
);

  mem_word_t mem [MEM_DEPTH];

  always_ff @(posedge axi_aclk) begin
    if (mem_en) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        rd_data <= mem[mem_addr];
      end
    end
  end

endmodule

/* hdl/replay_queue.sv */
// One replay engine, walks addr_low..addr_high inclusive replay_count times
// Window and count are latched at start, later register writes apply to the next run
// At most two words held, buffered plus in flight
`timescale 1ns/1ps

module replay_queue import replay_pkg::*; (
  input  logic        axi_aclk,
  input  logic        rst,
  input  logic        sw_rst,
  input  logic        start,
  input  logic        enable,
  input  replay_cnt_t replay_count,
  input  mem_addr_t   addr_low,
  input  mem_addr_t   addr_high,
  input  logic        gnt,
  input  logic        rd_ret,
  input  mem_word_t   rd_data,
  input  logic        m_ready,
  output logic        req,
  output mem_addr_t   req_addr,
  output pkt_data_t   m_data,
  output logic        m_last,
  output logic        m_valid
);

  queue_state_t state;
  logic         clr;
  logic         start_d;
  logic         go;
  logic         push;
  logic         pop;
  mem_addr_t    rd_addr;
  mem_addr_t    win_lo;
  mem_addr_t    win_hi;
  replay_cnt_t  passes_left;
  logic [1:0]   pend;
  logic [1:0]   fill;
  logic         wr_ptr;
  logic         rd_ptr;
  mem_word_t    fifo [2];

  assign clr = rst | sw_rst;

  // Start on a rising start bit, only from idle with a sane window
  assign go = start && !start_d && enable && (state == Q_IDLE) &&
              (replay_count != '0) && (addr_high >= addr_low);

  assign req      = (state == Q_RUN) && ((int'(pend) + int'(fill)) < 2);
  assign req_addr = rd_addr;

  // Returns after a soft reset have no slot and are dropped
  assign push = rd_ret && (pend != 2'd0);
  assign pop  = m_valid && m_ready;

  assign m_valid = (fill != 2'd0);
  assign m_data  = fifo[rd_ptr][WORD_W-1:0];
  assign m_last  = fifo[rd_ptr][WORD_W];

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      start_d <= 1'b0;
    end else begin
      start_d <= start;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (clr) begin
      state       <= Q_IDLE;
      rd_addr     <= '0;
      win_lo      <= '0;
      win_hi      <= '0;
      passes_left <= '0;
    end else begin
      case (state)
        Q_IDLE: begin
          if (go) begin
            state       <= Q_RUN;
            rd_addr     <= addr_low;
            win_lo      <= addr_low;
            win_hi      <= addr_high;
            passes_left <= replay_count;
          end
        end
        Q_RUN: begin
          if (gnt) begin
            if (rd_addr == win_hi) begin
              // End of window, one pass issued
              rd_addr     <= win_lo;
              passes_left <= passes_left - 1'b1;
              if (passes_left == replay_cnt_t'(1)) begin
                state <= Q_DRAIN;
              end
            end else begin
              rd_addr <= rd_addr + 1'b1;
            end
          end
        end
        Q_DRAIN: begin
          if (pend == 2'd0 && fill == 2'd0) begin
            state <= Q_IDLE;
          end
        end
        default: state <= Q_IDLE;
      endcase
    end
  end

  // Occupancy and buffer pointers
  always_ff @(posedge axi_aclk) begin
    if (clr) begin
      pend   <= '0;
      fill   <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      pend <= pend + {1'b0, gnt} - {1'b0, push};
      fill <= fill + {1'b0, push} - {1'b0, pop};
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      fifo[wr_ptr] <= rd_data;
    end
  end

endmodule

/* hdl/pcap_replay_top.sv */
// Capture and replay engine with four replay queues on one packet memory
// Single clock, synchronous active-high reset, register sw_rst resets the data path only
`timescale 1ns/1ps

module pcap_replay_top import replay_pkg::*; (
  input  logic      axi_aclk,
  input  logic      rst,
  input  logic      reg_wr,
  input  logic      reg_rd,
  input  reg_addr_t reg_addr,
  input  reg_data_t reg_wdata,
  output reg_data_t reg_rdata,
  output logic      reg_rvalid,
  input  pkt_data_t s_data,
  input  logic      s_last,
  input  logic      s_valid,
  output logic      s_ready,
  output pkt_data_t m_data [NUM_QUEUES],
  output logic [NUM_QUEUES-1:0] m_last,
  output logic [NUM_QUEUES-1:0] m_valid,
  input  logic [NUM_QUEUES-1:0] m_ready
);

  logic        sw_rst;
  logic [NUM_QUEUES-1:0] start;
  logic [NUM_QUEUES-1:0] enable;
  replay_cnt_t replay_count [NUM_QUEUES];
  mem_addr_t   addr_low [NUM_QUEUES];
  mem_addr_t   addr_high [NUM_QUEUES];

  // Memory request side, queues in the low slots
  req_vec_t    req;
  req_vec_t    gnt;
  mem_addr_t   req_addr [NUM_REQ];
  logic        cap_wr_en;
  mem_word_t   cap_wr_data;

  logic        mem_en;
  logic        mem_we;
  mem_addr_t   mem_addr;
  mem_word_t   mem_wdata;
  mem_word_t   rd_data;
  logic [NUM_QUEUES-1:0] rd_ret;

  replay_regs u_regs (
    .axi_aclk     (axi_aclk),
    .rst          (rst),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .reg_rvalid   (reg_rvalid),
    .sw_rst       (sw_rst),
    .start        (start),
    .enable       (enable),
    .replay_count (replay_count),
    .addr_low     (addr_low),
    .addr_high    (addr_high)
  );

  pkt_capture u_capture (
    .axi_aclk (axi_aclk),
    .rst      (rst),
    .sw_rst   (sw_rst),
    .s_valid  (s_valid),
    .s_last   (s_last),
    .s_data   (s_data),
    .gnt      (gnt[CAP_IDX]),
    .s_ready  (s_ready),
    .req      (req[CAP_IDX]),
    .wr_en    (cap_wr_en),
    .wr_addr  (req_addr[CAP_IDX]),
    .wr_data  (cap_wr_data)
  );

  mem_arbiter u_arbiter (
    .axi_aclk    (axi_aclk),
    .rst         (rst),
    .req         (req),
    .req_addr    (req_addr),
    .cap_wr_en   (cap_wr_en),
    .cap_wr_data (cap_wr_data),
    .gnt         (gnt),
    .mem_en      (mem_en),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .rd_ret      (rd_ret)
  );

  pkt_mem u_mem (
    .axi_aclk  (axi_aclk),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .rd_data   (rd_data)
  );

  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
    replay_queue u_queue (
      .axi_aclk     (axi_aclk),
      .rst          (rst),
      .sw_rst       (sw_rst),
      .start        (start[q]),
      .enable       (enable[q]),
      .replay_count (replay_count[q]),
      .addr_low     (addr_low[q]),
      .addr_high    (addr_high[q]),
      .gnt          (gnt[q]),
      .rd_ret       (rd_ret[q]),
      .rd_data      (rd_data),
      .m_ready      (m_ready[q]),
      .req          (req[q]),
      .req_addr     (req_addr[q]),
      .m_data       (m_data[q]),
      .m_last       (m_last[q]),
      .m_valid      (m_valid[q])
    );
  end

endmodule

/* sim/tb_clock.sv */
// Free-running testbench clock, 100 ns period, starts low
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    // Half of the 100 ns period
    forever #50 clk = ~clk;
  end

endmodule

/* sim/pcap_replay_assert.sv */
// Concurrent checks on the arbiter grant, the output streams and register reads
// Bound into pcap_replay_top and sampled on the rising clock edge
`timescale 1ns/1ps

module pcap_replay_assert import replay_pkg::*; (
  input logic                  axi_aclk,
  input logic                  rst,
  input req_vec_t              req,
  input req_vec_t              gnt,
  input logic                  reg_rd,
  input logic                  reg_rvalid,
  input logic [NUM_QUEUES-1:0] m_valid,
  input logic [NUM_QUEUES-1:0] m_ready,
  input logic [NUM_QUEUES-1:0] m_last,
  input pkt_data_t             m_data [NUM_QUEUES]
);

  int fail_count = 0;

  // At most one requester owns the memory port, only one that asks, and never idle on a request
  assert property (@(posedge axi_aclk) disable iff (rst)
    $onehot0(gnt) && ((gnt & ~req) == '0) && ((req != '0) == (gnt != '0)))
    else begin
      $error("memory grant is not one-hot or does not match the requests");
      fail_count++;
    end

  // Read data valid exactly one cycle after the read strobe
  assert property (@(posedge axi_aclk) disable iff (rst) reg_rvalid == $past(reg_rd))
    else begin
      $error("reg_rvalid does not follow reg_rd by one cycle");
      fail_count++;
    end

  // Streams stay quiet through reset
  assert property (@(posedge axi_aclk) $past(rst) |-> (m_valid == '0))
    else begin
      $error("m_valid high during reset");
      fail_count++;
    end

  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_lane
    assert property (@(posedge axi_aclk) disable iff (rst)
      (m_valid[q] && !m_ready[q]) |=>
        (m_valid[q] && $stable(m_data[q]) && $stable(m_last[q])))
      else begin
        $error("stream %0d dropped or changed a word before m_ready", q);
        fail_count++;
      end
  end

endmodule

/* sim/pcap_replay_tb.sv */
// Testbench for the capture and replay engine driven by sim/replay_testdata.txt
// Must be run from the project root so the data file path resolves
// m_ready is random on every lane and each lane keeps its own expected order
`timescale 1ns/1ps

module pcap_replay_tb import replay_pkg::*; ();

  localparam int    CYCLES_PER_LINE = 200;
  localparam int    RDY_SEED        = 32'h560f94d0;
  localparam string DATA_FILE       = "sim/replay_testdata.txt";

  logic      axi_aclk;
  logic      rst;
  logic      reg_wr;
  logic      reg_rd;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      reg_rvalid;
  pkt_data_t s_data;
  logic      s_last;
  logic      s_valid;
  logic      s_ready;
  pkt_data_t m_data [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] m_last;
  logic [NUM_QUEUES-1:0] m_valid;
  logic [NUM_QUEUES-1:0] m_ready;

  // Expected words per lane with the last flag on top
  mem_word_t exp_q [NUM_QUEUES][$];
  string     cmds [$];
  int        num_lines;
  bit        loaded;

  tb_clock u_clock (
    .clk (axi_aclk)
  );

  pcap_replay_top u_pcap_replay_top (
    .axi_aclk   (axi_aclk),
    .rst        (rst),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .s_data     (s_data),
    .s_last     (s_last),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .m_data     (m_data),
    .m_last     (m_last),
    .m_valid    (m_valid),
    .m_ready    (m_ready)
  );

  bind pcap_replay_top pcap_replay_assert u_assert (
    .axi_aclk   (axi_aclk),
    .rst        (rst),
    .req        (req),
    .gnt        (gnt),
    .reg_rd     (reg_rd),
    .reg_rvalid (reg_rvalid),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_last     (m_last),
    .m_data     (m_data)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_reg(input reg_addr_t idx, input reg_data_t exp_val,
                           input reg_data_t act_val);
    if (act_val !== exp_val) begin
      stop_run($sformatf("ERR t=%0t reg_rdata[%0d] expected %h actual %h",
                         $time, idx, exp_val, act_val));
    end
  endtask

  task automatic check_word(input int lane, input pkt_data_t exp_data, input logic exp_last,
                            input pkt_data_t act_data, input logic act_last);
    if (act_data !== exp_data) begin
      stop_run($sformatf("ERR t=%0t m_data[%0d] expected %h actual %h",
                         $time, lane, exp_data, act_data));
    end else if (act_last !== exp_last) begin
      stop_run($sformatf("ERR t=%0t m_last[%0d] expected %b actual %b",
                         $time, lane, exp_last, act_last));
    end
  endtask

  task automatic write_reg(input reg_addr_t idx, input reg_data_t val);
    @(posedge axi_aclk);
    reg_wr    <= 1'b1;
    reg_addr  <= idx;
    reg_wdata <= val;
    @(posedge axi_aclk);
    reg_wr <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t idx, input reg_data_t exp_val);
    @(posedge axi_aclk);
    reg_rd   <= 1'b1;
    reg_addr <= idx;
    @(posedge axi_aclk);
    reg_rd <= 1'b0;
    // Data is due one cycle after the strobe
    @(negedge axi_aclk);
    if (!reg_rvalid) begin
      stop_run($sformatf("Register read of index %0d returned no data one cycle later",
                         idx));
    end else begin
      check_reg(idx, exp_val, reg_rdata);
    end
  endtask

  // Hold the word until the capture port is granted
  task automatic capture_word(input pkt_data_t data, input logic last);
    @(posedge axi_aclk);
    s_valid <= 1'b1;
    s_data  <= data;
    s_last  <= last;
    @(negedge axi_aclk);
    while (!s_ready) begin
      @(negedge axi_aclk);
    end
    @(posedge axi_aclk);
    s_valid <= 1'b0;
  endtask

  task automatic expect_word(input int lane, input pkt_data_t data, input logic last);
    if (lane >= NUM_QUEUES) begin
      stop_run($sformatf("Test data names queue %0d, which does not exist", lane));
    end else begin
      exp_q[lane].push_back({last, data});
    end
  endtask

  function automatic logic queues_idle();
    return (u_pcap_replay_top.g_queue[0].u_queue.state == Q_IDLE) &&
           (u_pcap_replay_top.g_queue[1].u_queue.state == Q_IDLE) &&
           (u_pcap_replay_top.g_queue[2].u_queue.state == Q_IDLE) &&
           (u_pcap_replay_top.g_queue[3].u_queue.state == Q_IDLE);
  endfunction

  function automatic logic expected_drained();
    logic done;
    done = 1'b1;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (exp_q[q].size() != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // Gives a fresh start time to leave idle before polling
  task automatic wait_idle();
    repeat (4) @(posedge axi_aclk);
    while (!(queues_idle() && expected_drained())) begin
      @(posedge axi_aclk);
    end
  endtask

  // Transfers are sampled mid-cycle where the streams are stable
  always @(negedge axi_aclk) begin
    mem_word_t exp_w;
    if (!rst) begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (m_valid[q] && m_ready[q]) begin
          if (exp_q[q].size() == 0) begin
            stop_run($sformatf("Queue %0d sent word %h that was not expected",
                               q, m_data[q]));
          end else begin
            exp_w = exp_q[q].pop_front();
            check_word(q, exp_w[WORD_W-1:0], exp_w[WORD_W], m_data[q], m_last[q]);
          end
        end
      end
    end
  end

  // Bound assertions count their failures
  always @(negedge axi_aclk) begin
    if (u_pcap_replay_top.u_assert.fail_count != 0) begin
      stop_run("A bound assertion on the DUT failed");
    end
  end

  // Random back-pressure with ready on about three cycles of four
  initial begin
    void'($urandom(RDY_SEED));
    m_ready = '0;
    forever begin
      @(posedge axi_aclk);
      for (int q = 0; q < NUM_QUEUES; q++) begin
        m_ready[q] <= (($urandom % 4) != 0);
      end
    end
  end

  initial begin
    wait (loaded);
    repeat ((num_lines + 5) * CYCLES_PER_LINE) @(posedge axi_aclk);
    stop_run($sformatf("Run timed out, %0d test data lines did not finish in time",
                       num_lines));
  end

  initial begin
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    rst       = 1'b1;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    s_data    = '0;
    s_last    = 1'b0;
    s_valid   = 1'b0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      stop_run("Could not open the test data file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        cmds.push_back(line);
      end
    end
    $fclose(fd);
    num_lines = cmds.size();
    loaded    = 1'b1;

    repeat (5) @(posedge axi_aclk);
    rst <= 1'b0;

    foreach (cmds[i]) begin
      a = '0;
      b = '0;
      c = '0;
      n = $sscanf(cmds[i], "%c %h %h %h", tag, a, b, c);
      case (tag)
        "W": write_reg(reg_addr_t'(a), b);
        "R": read_reg(reg_addr_t'(a), b);
        "C": capture_word(a, b[0]);
        "E": expect_word(int'(a), b, c[0]);
        "G": wait_idle();
        default: stop_run($sformatf("Unknown command in test data: %s", cmds[i]));
      endcase
    end

    @(negedge axi_aclk);
    if (u_pcap_replay_top.u_assert.fail_count != 0) begin
      stop_run("A bound assertion on the DUT failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* sim/replay_testdata.txt */
# W idx value | R idx expected | C data last | E queue data last | G wait for idle
# All numbers hex, register index map: 0 sw_rst, 1 start, 5 count, 9 low/high, 17 enable
R 00 0
R 01 0
R 02 0
R 03 0
R 04 0
R 05 0
R 06 0
R 07 0
R 08 0
R 09 0
R 0a 0
R 0b 0
R 0c 0
R 0d 0
R 0e 0
R 0f 0
R 10 0
R 11 0
R 12 0
R 13 0
R 14 0
R 15 0
R 1f 0
W 0d 12345678
R 0d 12345678
W 15 deadbeef
R 15 0
# Sixteen words, four packets of four
C c0de0000 0
C c0de0001 0
C c0de0002 0
C c0de0003 1
C c0de0004 0
C c0de0005 0
C c0de0006 0
C c0de0007 1
C c0de0008 0
C c0de0009 0
C c0de000a 0
C c0de000b 1
C c0de000c 0
C c0de000d 0
C c0de000e 0
C c0de000f 1
# Queue 0, window 0 to 3, one pass
W 0a 3
W 05 1
W 11 1
E 0 c0de0000 0
E 0 c0de0001 0
E 0 c0de0002 0
E 0 c0de0003 1
W 01 1
G
# Three passes back to back
W 01 0
W 05 3
E 0 c0de0000 0
E 0 c0de0001 0
E 0 c0de0002 0
E 0 c0de0003 1
E 0 c0de0000 0
E 0 c0de0001 0
E 0 c0de0002 0
E 0 c0de0003 1
E 0 c0de0000 0
E 0 c0de0001 0
E 0 c0de0002 0
E 0 c0de0003 1
W 01 1
G
# Count of zero sends nothing
W 01 0
W 05 0
W 01 1
G
# All four queues on overlapping windows
W 01 0
W 05 1
W 0a 1
W 0b 1
W 0c 2
W 06 2
W 12 1
W 0d 2
W 0e 4
W 07 1
W 13 1
W 0f e
W 10 f
W 08 1
W 14 1
E 0 c0de0000 0
E 0 c0de0001 0
E 1 c0de0001 0
E 1 c0de0002 0
E 1 c0de0001 0
E 1 c0de0002 0
E 2 c0de0002 0
E 2 c0de0003 1
E 2 c0de0004 0
E 3 c0de000e 0
E 3 c0de000f 1
W 01 1
W 02 1
W 03 1
W 04 1
G
# Queue 3 disabled, start edge ignored
W 14 0
W 04 0
W 04 1
G
# Soft reset, capture restarts at address 0
W 00 1
W 00 0
R 05 1
C 5eed0000 0
C 5eed0001 1
C 5eed0002 0
C 5eed0003 1
W 0a 3
E 0 5eed0000 0
E 0 5eed0001 1
E 0 5eed0002 0
E 0 5eed0003 1
W 01 0
W 01 1
G

/* list.f */
hdl/replay_pkg.sv
hdl/replay_regs.sv
hdl/pkt_capture.sv
hdl/mem_arbiter.sv
hdl/pkt_mem.sv
hdl/replay_queue.sv
hdl/pcap_replay_top.sv
sim/tb_clock.sv
sim/pcap_replay_assert.sv
sim/pcap_replay_tb.sv
